//--- mipsIsaPkg.sv
// MIPS-I subset encodings, only the opcodes and function codes the core executes
// Anything not listed here decodes as a no-op
package mipsIsaPkg;

    localparam int regAddrWidth = 5;  // 32 architectural registers
    localparam int immWidth = 16;
    localparam logic [regAddrWidth-1:0] regV0 = 5'd2;  // Result register, visible at the top

    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,   // Selected further by funct
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDIU = 6'd9,
        OP_SLTI  = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14,
        OP_LUI   = 6'd15,
        OP_LB    = 6'd32,
        OP_LW    = 6'd35,
        OP_LBU   = 6'd36,
        OP_SB    = 6'd40,
        OP_SW    = 6'd43
    } opcodeT;

    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_SLLV = 6'd4,
        FN_SRLV = 6'd6,
        FN_SRAV = 6'd7,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } functT;

endpackage

//--- cpuCorePkg.sv
// Core datapath and bus sizes, controller states, ALU operations
// Byte addresses, one 32-bit word per bus beat
package cpuCorePkg;

    localparam int dataWidth = 32;
    localparam int byteEnWidth = dataWidth / 8;

    typedef enum logic [1:0] {
        FETCH = 2'd0,  // Instruction read on the bus
        EXEC  = 2'd1,  // Single cycle, ALU and next PC
        MEM   = 2'd2,  // Data read or write
        HALT  = 2'd3   // Left only by reset
    } ctrlStateT;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, LUI, SLT, SLTU, SLL, SRL, SRA
    } aluOpT;

endpackage

//--- regFile.sv
// 32 x 32 register file, two combinational reads, one write at the clock edge
// Register 0 is never written, so it reads zero after reset
`timescale 1ns/1ps

module regFile (
    input  logic clk,
    input  logic reset,
    input  logic [mipsIsaPkg::regAddrWidth-1:0] rsAddr,
    input  logic [mipsIsaPkg::regAddrWidth-1:0] rtAddr,
    input  logic writeEn,
    input  logic [mipsIsaPkg::regAddrWidth-1:0] writeAddr,
    input  logic [cpuCorePkg::dataWidth-1:0] writeData,
    output logic [cpuCorePkg::dataWidth-1:0] rsValue,
    output logic [cpuCorePkg::dataWidth-1:0] rtValue,
    output logic [cpuCorePkg::dataWidth-1:0] v0Value
);
    import cpuCorePkg::*;
    import mipsIsaPkg::*;

    logic [dataWidth-1:0] regs [2**regAddrWidth];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin  // $zero stays zero
            regs[writeAddr] <= writeData;
        end
    end

    assign rsValue = regs[rsAddr];
    assign rtValue = regs[rtAddr];
    assign v0Value = regs[regV0];  // Brought out as registerV0

endmodule

//--- alu.sv
// Combinational ALU, the immediate is extended here as the decoder asks
// Variable shifts take rs[4:0], fixed shifts take shamt
`timescale 1ns/1ps

module alu (
    input  cpuCorePkg::aluOpT aluOp,
    input  logic [cpuCorePkg::dataWidth-1:0] rsValue,
    input  logic [cpuCorePkg::dataWidth-1:0] rtValue,
    input  logic [mipsIsaPkg::immWidth-1:0] immValue,
    input  logic signExtImm,
    input  logic useImm,
    input  logic [4:0] shamt,
    input  logic useShamt,
    input  logic branchOnEqual,
    output logic [cpuCorePkg::dataWidth-1:0] aluResult,
    output logic branchTaken
);
    import cpuCorePkg::*;
    import mipsIsaPkg::*;

    logic [dataWidth-1:0] extImm;
    logic [dataWidth-1:0] opB;
    logic [4:0] shiftAmt;

    assign extImm = signExtImm ? {{(dataWidth-immWidth){immValue[immWidth-1]}}, immValue}
                               : {{(dataWidth-immWidth){1'b0}}, immValue};
    assign opB = useImm ? extImm : rtValue;
    assign shiftAmt = useShamt ? shamt : rsValue[4:0];

    always_comb begin
        case (aluOp)
            ADD:     aluResult = rsValue + opB;  // Also effective address
            SUB:     aluResult = rsValue - opB;
            AND:     aluResult = rsValue & opB;
            OR:      aluResult = rsValue | opB;
            XOR:     aluResult = rsValue ^ opB;
            LUI:     aluResult = {immValue, {(dataWidth-immWidth){1'b0}}};
            SLT:     aluResult = {{(dataWidth-1){1'b0}}, $signed(rsValue) < $signed(opB)};
            SLTU:    aluResult = {{(dataWidth-1){1'b0}}, rsValue < opB};  // SLTIU too, sign-extended
            SLL:     aluResult = rtValue << shiftAmt;
            SRL:     aluResult = rtValue >> shiftAmt;
            SRA:     aluResult = $signed(rtValue) >>> shiftAmt;  // Keeps the sign
            default: aluResult = '0;
        endcase
    end

    // BEQ on equality, BNE on inequality
    assign branchTaken = (rsValue == rtValue) == branchOnEqual;

endmodule

//--- instrDecode.sv
// Pure decode of the held instruction word
// Unknown opcodes and functs write nothing and touch no memory
// loadKind bit 1 marks a byte load, bit 0 an unsigned one
`timescale 1ns/1ps

module instrDecode (
    input  logic [cpuCorePkg::dataWidth-1:0] instr,
    output logic [mipsIsaPkg::regAddrWidth-1:0] rsAddr,
    output logic [mipsIsaPkg::regAddrWidth-1:0] rtAddr,
    output logic [mipsIsaPkg::regAddrWidth-1:0] destReg,
    output cpuCorePkg::aluOpT aluOp,
    output logic useImm,
    output logic signExtImm,
    output logic [mipsIsaPkg::immWidth-1:0] immValue,
    output logic [4:0] shamt,
    output logic useShamt,
    output logic regWriteEn,
    output logic isLoad,
    output logic isStore,
    output logic isJump,
    output logic isJumpReg,
    output logic isBranch,
    output logic branchOnEqual,
    output logic [1:0] loadKind,
    output logic storeIsByte,
    output logic [25:0] jumpTarget,
    output logic [cpuCorePkg::dataWidth-1:0] branchOffset
);
    import cpuCorePkg::*;
    import mipsIsaPkg::*;

    opcodeT opcode;
    functT funct;

    assign opcode = opcodeT'(instr[31:26]);
    assign funct = functT'(instr[5:0]);
    assign rsAddr = instr[25:21];
    assign rtAddr = instr[20:16];
    assign shamt = instr[10:6];
    assign immValue = instr[15:0];
    assign jumpTarget = instr[25:0];
    assign branchOffset = {{(dataWidth-immWidth-2){instr[15]}}, instr[15:0], 2'b00};  // Words to bytes

    always_comb begin
        destReg = rtAddr;  // I-type default
        aluOp = ADD;
        useImm = 1'b1;
        signExtImm = 1'b1;
        useShamt = 1'b0;
        regWriteEn = 1'b0;
        isLoad = 1'b0;
        isStore = 1'b0;
        isJump = 1'b0;
        isJumpReg = 1'b0;
        isBranch = 1'b0;
        branchOnEqual = 1'b1;
        loadKind = 2'b00;  // Word
        storeIsByte = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                destReg = instr[15:11];
                useImm = 1'b0;
                regWriteEn = 1'b1;
                case (funct)
                    FN_ADDU: aluOp = ADD;
                    FN_SUBU: aluOp = SUB;
                    FN_AND:  aluOp = AND;
                    FN_OR:   aluOp = OR;
                    FN_XOR:  aluOp = XOR;
                    FN_SLT:  aluOp = SLT;
                    FN_SLTU: aluOp = SLTU;
                    FN_SLLV: aluOp = SLL;
                    FN_SRLV: aluOp = SRL;
                    FN_SRAV: aluOp = SRA;
                    FN_SLL, FN_SRL, FN_SRA: begin
                        useShamt = 1'b1;
                        aluOp = (funct == FN_SLL) ? SLL : (funct == FN_SRL) ? SRL : SRA;
                    end
                    FN_JR: begin
                        isJumpReg = 1'b1;
                        regWriteEn = 1'b0;
                    end
                    default: regWriteEn = 1'b0;
                endcase
            end
            OP_ADDIU: regWriteEn = 1'b1;
            OP_SLTI, OP_SLTIU: begin
                aluOp = (opcode == OP_SLTI) ? SLT : SLTU;
                regWriteEn = 1'b1;
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                aluOp = (opcode == OP_ANDI) ? AND : (opcode == OP_ORI) ? OR : XOR;
                signExtImm = 1'b0;  // Logic immediates zero-extend
                regWriteEn = 1'b1;
            end
            OP_LUI: begin
                aluOp = LUI;
                regWriteEn = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                isBranch = 1'b1;
                branchOnEqual = (opcode == OP_BEQ);
            end
            OP_J: isJump = 1'b1;
            OP_LW, OP_LB, OP_LBU: begin
                isLoad = 1'b1;
                regWriteEn = 1'b1;  // Written back in MEM
                loadKind = (opcode == OP_LW) ? 2'b00 : (opcode == OP_LB) ? 2'b10 : 2'b11;
            end
            OP_SW, OP_SB: begin
                isStore = 1'b1;
                storeIsByte = (opcode == OP_SB);
            end
            default: useImm = 1'b0;  // No-op
        endcase
    end

endmodule

//--- loadStoreUnit.sv
// Little-endian lanes, lane = address mod 4
// Word accesses assume an aligned address
`timescale 1ns/1ps

module loadStoreUnit (
    input  logic [cpuCorePkg::dataWidth-1:0] effAddr,
    input  logic [cpuCorePkg::dataWidth-1:0] rtValue,
    input  logic storeIsByte,
    input  logic [1:0] loadKind,
    input  logic [cpuCorePkg::dataWidth-1:0] readData,
    output logic [cpuCorePkg::byteEnWidth-1:0] byteEnable,
    output logic [cpuCorePkg::dataWidth-1:0] writeData,
    output logic [cpuCorePkg::dataWidth-1:0] loadValue
);
    import cpuCorePkg::*;

    logic [1:0] lane;
    logic [7:0] laneByte;

    assign lane = effAddr[1:0];

    // SB repeats the byte on every lane, the enable picks one
    assign byteEnable = storeIsByte ? byteEnWidth'(1) << lane : '1;
    assign writeData = storeIsByte ? {byteEnWidth{rtValue[7:0]}} : rtValue;

    assign laneByte = readData[lane*8 +: 8];

    always_comb begin
        case (loadKind)
            2'b10:   loadValue = {{(dataWidth-8){laneByte[7]}}, laneByte};  // LB
            2'b11:   loadValue = {{(dataWidth-8){1'b0}}, laneByte};         // LBU
            default: loadValue = readData;                                  // LW
        endcase
    end

endmodule

//--- cpuControl.sv
// Multicycle controller FETCH, EXEC, then MEM for loads and stores
// No delay slots, a taken branch or jump redirects the PC directly
// A jump or JR to address zero halts until the next reset
`timescale 1ns/1ps

module cpuControl #(
    parameter logic [31:0] resetVector = 32'hBFC00000
) (
    input  logic clk,
    input  logic reset,
    input  logic waitRequest,
    input  logic [cpuCorePkg::dataWidth-1:0] readData,
    input  logic [cpuCorePkg::dataWidth-1:0] aluResult,
    input  logic branchTaken,
    input  logic isLoad,
    input  logic isStore,
    input  logic isJump,
    input  logic isJumpReg,
    input  logic isBranch,
    input  logic regWriteEn,
    input  logic [mipsIsaPkg::regAddrWidth-1:0] destReg,
    input  logic [25:0] jumpTarget,
    input  logic [cpuCorePkg::dataWidth-1:0] branchOffset,
    input  logic [cpuCorePkg::dataWidth-1:0] loadValue,
    input  logic [cpuCorePkg::dataWidth-1:0] rsValue,
    output logic [cpuCorePkg::dataWidth-1:0] instr,
    output logic [cpuCorePkg::dataWidth-1:0] address,
    output logic read,
    output logic write,
    output logic active,
    output logic [cpuCorePkg::dataWidth-1:0] effAddr,
    output logic rfWriteEn,
    output logic [mipsIsaPkg::regAddrWidth-1:0] rfWriteAddr,
    output logic [cpuCorePkg::dataWidth-1:0] rfWriteData
);
    import cpuCorePkg::*;

    ctrlStateT state;
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] instrReg;
    logic [dataWidth-1:0] pcPlus4;
    logic [dataWidth-1:0] jumpDest;
    logic [dataWidth-1:0] nextPc;
    logic haltJump;

    assign pcPlus4 = pc + dataWidth'(4);
    assign jumpDest = isJumpReg ? rsValue : {pcPlus4[31:28], jumpTarget, 2'b00};
    assign haltJump = (isJump || isJumpReg) && (jumpDest == '0);

    always_comb begin
        if (isJump || isJumpReg)
            nextPc = jumpDest;
        else if (isBranch && branchTaken)
            nextPc = pcPlus4 + branchOffset;  // Relative to the following instruction
        else
            nextPc = pcPlus4;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc <= resetVector;
        end else begin
            case (state)
                FETCH: if (!waitRequest) state <= EXEC;
                EXEC: begin
                    if (isLoad || isStore) begin
                        state <= MEM;  // PC held until the data beat ends
                    end else if (haltJump) begin
                        state <= HALT;
                    end else begin
                        pc <= nextPc;
                        state <= FETCH;
                    end
                end
                MEM: begin
                    if (!waitRequest) begin
                        pc <= pcPlus4;
                        state <= FETCH;
                    end
                end
                default: state <= HALT;  // Stuck until reset
            endcase
        end
    end

    // Instruction captured as the fetch completes
    always_ff @(posedge clk) begin
        if (state == FETCH && !waitRequest)
            instrReg <= readData;
    end

    assign instr = instrReg;
    assign effAddr = aluResult;  // rs + imm, steady through MEM
    // No requests while reset is high
    assign read = !reset && ((state == FETCH) || (state == MEM && isLoad));
    assign write = !reset && (state == MEM) && isStore;
    assign address = (state == FETCH) ? pc : {aluResult[dataWidth-1:2], 2'b00};  // Word aligned
    assign active = (state != HALT);

    // ALU results in EXEC, loads when the read beat completes
    assign rfWriteEn = regWriteEn && (isLoad ? (state == MEM && !waitRequest) : (state == EXEC));
    assign rfWriteAddr = destReg;
    assign rfWriteData = (state == MEM) ? loadValue : aluResult;

endmodule

//--- mipsCpuBus.sv
// MIPS subset CPU with an Avalon-MM master, one transfer outstanding at most
// Byte addresses, word aligned on the bus, lanes picked by byteEnable
// Execution starts at resetVector, active falls after a jump to zero
`timescale 1ns/1ps

module mipsCpuBus #(
    parameter logic [31:0] resetVector = 32'hBFC00000
) (
    input  logic clk,
    input  logic reset,
    output logic active,
    output logic [cpuCorePkg::dataWidth-1:0] registerV0,
    output logic [cpuCorePkg::dataWidth-1:0] address,
    output logic read,
    output logic write,
    input  logic waitRequest,
    output logic [cpuCorePkg::dataWidth-1:0] writeData,
    output logic [cpuCorePkg::byteEnWidth-1:0] byteEnable,
    input  logic [cpuCorePkg::dataWidth-1:0] readData
);
    import cpuCorePkg::*;
    import mipsIsaPkg::*;

    logic [dataWidth-1:0] instr;
    logic [dataWidth-1:0] rsValue;
    logic [dataWidth-1:0] rtValue;
    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] effAddr;
    logic [dataWidth-1:0] loadValue;
    logic [dataWidth-1:0] branchOffset;
    logic [dataWidth-1:0] rfWriteData;
    logic [regAddrWidth-1:0] rsAddr;
    logic [regAddrWidth-1:0] rtAddr;
    logic [regAddrWidth-1:0] destReg;
    logic [regAddrWidth-1:0] rfWriteAddr;
    logic [immWidth-1:0] immValue;
    logic [byteEnWidth-1:0] lsuByteEnable;
    logic [25:0] jumpTarget;
    logic [4:0] shamt;
    logic [1:0] loadKind;
    aluOpT aluOp;
    logic useImm;
    logic signExtImm;
    logic useShamt;
    logic regWriteEn;
    logic isLoad;
    logic isStore;
    logic isJump;
    logic isJumpReg;
    logic isBranch;
    logic branchOnEqual;
    logic storeIsByte;
    logic branchTaken;
    logic rfWriteEn;

    cpuControl #(.resetVector(resetVector)) uControl (
        .clk, .reset, .waitRequest, .readData, .aluResult, .branchTaken,
        .isLoad, .isStore, .isJump, .isJumpReg, .isBranch, .regWriteEn, .destReg,
        .jumpTarget, .branchOffset, .loadValue, .rsValue,
        .instr, .address, .read, .write, .active, .effAddr,
        .rfWriteEn, .rfWriteAddr, .rfWriteData
    );

    instrDecode uDecode (
        .instr, .rsAddr, .rtAddr, .destReg, .aluOp, .useImm, .signExtImm, .immValue,
        .shamt, .useShamt, .regWriteEn, .isLoad, .isStore, .isJump, .isJumpReg,
        .isBranch, .branchOnEqual, .loadKind, .storeIsByte, .jumpTarget, .branchOffset
    );

    regFile uRegs (
        .clk, .reset, .rsAddr, .rtAddr,
        .writeEn(rfWriteEn), .writeAddr(rfWriteAddr), .writeData(rfWriteData),
        .rsValue, .rtValue, .v0Value(registerV0)
    );

    alu uAlu (
        .aluOp, .rsValue, .rtValue, .immValue, .signExtImm, .useImm,
        .shamt, .useShamt, .branchOnEqual, .aluResult, .branchTaken
    );

    loadStoreUnit uLsu (
        .effAddr, .rtValue, .storeIsByte, .loadKind, .readData,
        .byteEnable(lsuByteEnable), .writeData, .loadValue
    );

    assign byteEnable = reset ? '0 : lsuByteEnable;  // Lanes off while in reset

endmodule

//--- tbMemory.sv
// Avalon-MM slave RAM for the testbench, 256 words, decodes address[9:2] only
// Code at the reset vector and data near 0x200 share one array by aliasing
// Random stalls come from $urandom, at most maxStall in a row
`timescale 1ns/1ps

module tbMemory #(
    parameter int maxStall = 3
) (
    input  logic clk,
    input  logic reset,
    input  logic [31:0] address,
    input  logic read,
    input  logic write,
    input  logic [31:0] writeData,
    input  logic [3:0] byteEnable,
    output logic waitRequest,
    output logic [31:0] readData,
    input  logic loadEn,         // Backdoor program load
    input  logic [31:0] loadAddr,
    input  logic [31:0] loadData,
    input  logic [31:0] peekAddr, // Backdoor readback
    output logic [31:0] peekData
);
    logic [31:0] words [256];
    logic stall;
    int stallRun;

    // Fill pattern mixes every index bit
    initial begin
        for (int i = 0; i < 256; i++) begin
            words[i] = 32'hA5A50000 ^ (32'(i) * 32'h00010004);
        end
    end

    assign waitRequest = (read || write) && stall;  // Only seen during a request
    assign readData = words[address[9:2]];           // Valid in the completing cycle
    assign peekData = words[peekAddr[9:2]];

    always @(posedge clk) begin
        logic nextStall;
        nextStall = (stallRun < maxStall) && ($urandom_range(2, 0) == 0);
        if (reset) begin
            stall <= 1'b0;
            stallRun <= 0;
        end else begin
            stall <= nextStall;
            stallRun <= nextStall ? stallRun + 1 : 0;  // Caps a stall burst
        end
        if (loadEn) begin
            words[loadAddr[9:2]] <= loadData;
        end else if (write && !waitRequest) begin
            for (int b = 0; b < 4; b++) begin
                if (byteEnable[b])
                    words[address[9:2]][b*8 +: 8] <= writeData[b*8 +: 8];
            end
        end
    end

endmodule

//--- tbMipsCpu.sv
// Table-driven testbench, one small program per entry, each ends with JR to zero
// Expected values are hand-worked MIPS results, independent of bus stalls
// Programs are loaded through a backdoor port while the core is halted or in reset
`timescale 1ns/1ps

module tbMipsCpu;
    localparam logic [31:0] resetVector = 32'hBFC00000;
    localparam int numTests = 6;
    localparam int maxWords = 24;
    localparam int maxStall = 3;
    localparam int resetCycles = 5;
    localparam int idleCycles = 8;               // Quiet bus check after halt
    localparam int worstCpi = 3 + 2 * maxStall;  // Fetch, exec, mem with full stalls

    logic clk = 1'b0;
    logic reset;
    logic active;
    logic [31:0] registerV0;
    logic [31:0] address;
    logic read;
    logic write;
    logic waitRequest;
    logic [31:0] writeData;
    logic [3:0] byteEnable;
    logic [31:0] readData;
    logic loadEn;
    logic [31:0] loadAddr;
    logic [31:0] loadData;
    logic [31:0] peekAddr;
    logic [31:0] peekData;

    // Test table
    logic [31:0] progWords [numTests][maxWords];
    int progLen [numTests];
    logic [31:0] expV0 [numTests];
    logic [31:0] dataAddr [numTests];
    logic [31:0] expData [numTests];
    string testName [numTests];

    int curTest = -1;
    int errorCount = 0;
    int failedTests = 0;
    int cycleCount = 0;
    int cycleLimit = 0;  // Zero until the table is built

    always #2 clk = ~clk;  // 4 ns period

    mipsCpuBus #(.resetVector(resetVector)) dut (
        .clk, .reset, .active, .registerV0, .address, .read, .write,
        .waitRequest, .writeData, .byteEnable, .readData
    );

    tbMemory #(.maxStall(maxStall)) ram (
        .clk, .reset, .address, .read, .write, .writeData, .byteEnable,
        .waitRequest, .readData, .loadEn, .loadAddr, .loadData, .peekAddr, .peekData
    );

    // MIPS encoders, register numbers and immediates as plain ints
    function automatic logic [31:0] rType(int rs, int rt, int rd, int sa, int fn);
        return {6'd0, rs[4:0], rt[4:0], rd[4:0], sa[4:0], fn[5:0]};
    endfunction

    function automatic logic [31:0] iType(int op, int rs, int rt, int imm);
        return {op[5:0], rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] codeAddr(int idx);
        return resetVector + 32'(4 * idx);
    endfunction

    function automatic logic [31:0] jType(int idx);  // J to program word idx
        logic [31:0] dest;
        dest = codeAddr(idx);
        return {6'd2, dest[27:2]};
    endfunction

    task automatic startTest(input string name, input logic [31:0] v0,
                             input logic [31:0] addr, input logic [31:0] data);
        curTest++;
        testName[curTest] = name;
        expV0[curTest] = v0;
        dataAddr[curTest] = addr;
        expData[curTest] = data;
        progLen[curTest] = 0;
    endtask

    task automatic emit(input logic [31:0] word);
        progWords[curTest][progLen[curTest]] = word;
        progLen[curTest]++;
    endtask

    task automatic buildTable();
        startTest("R-type ALU", 32'hFFFFFFF6, 32'h300, 32'h0);
        emit(iType(9, 0, 8, 5));           // addiu $8, $0, 5
        emit(iType(9, 0, 9, -3));          // addiu $9, $0, -3
        emit(rType(8, 9, 2, 0, 33));       // addu $2, $8, $9   = 2
        emit(rType(8, 9, 10, 0, 35));      // subu $10 = 8
        emit(rType(8, 9, 11, 0, 36));      // and  $11 = 5
        emit(rType(8, 9, 12, 0, 37));      // or   $12 = fffffffd
        emit(rType(8, 9, 13, 0, 38));      // xor  $13 = fffffff8
        emit(rType(9, 8, 14, 0, 42));      // slt  $14, $9, $8 = 1
        emit(rType(9, 8, 15, 0, 43));      // sltu $15, $9, $8 = 0
        emit(rType(8, 8, 0, 0, 33));       // addu $0 discarded
        emit(rType(2, 10, 2, 0, 33));      // v0 = a
        emit(rType(2, 11, 2, 0, 33));      // v0 = f
        emit(rType(2, 13, 2, 0, 38));      // v0 = fffffff7
        emit(rType(2, 12, 2, 0, 36));      // v0 = fffffff5
        emit(rType(2, 14, 2, 0, 33));      // v0 = fffffff6
        emit(rType(2, 15, 2, 0, 33));
        emit(iType(43, 0, 0, 'h300));      // sw $0, 0x300($0)
        emit(rType(0, 0, 0, 0, 8));        // jr $0, halt
        startTest("immediates", 32'h1232800F, 32'h304, 32'hFFFFFFF0);
        emit(iType(9, 0, 8, -16));         // addiu $8 = fffffff0
        emit(iType(12, 8, 9, 'hFF0F));     // andi $9 = 0000ff00
        emit(iType(13, 0, 10, 'h8001));    // ori $10 = 00008001, no sign extension
        emit(iType(14, 8, 11, 'hFF));      // xori $11 = ffffff0f
        emit(iType(15, 0, 12, 'h1234));    // lui $12 = 12340000
        emit(iType(10, 8, 13, 5));         // slti $13 = 1
        emit(iType(11, 8, 14, 5));         // sltiu $14 = 0
        emit(rType(9, 10, 2, 0, 33));      // v0 = 00017f01
        emit(rType(2, 11, 2, 0, 38));      // v0 = fffe800e
        emit(rType(2, 12, 2, 0, 33));      // v0 = 1232800e
        emit(rType(2, 13, 2, 0, 33));
        emit(rType(2, 14, 2, 0, 33));
        emit(iType(43, 0, 8, 'h304));      // sw $8, 0x304($0)
        emit(rType(0, 0, 0, 0, 8));
        startTest("shifts", 32'hAD9421FF, 32'h308, 32'hFF84210F);
        emit(iType(15, 0, 8, 'h8421));     // lui $8
        emit(iType(13, 8, 8, 'h0F0F));     // $8 = 84210f0f
        emit(iType(9, 0, 9, 44));          // $9 = 44, low five bits 12
        emit(rType(0, 8, 10, 4, 0));       // sll  $10 = 4210f0f0
        emit(rType(0, 8, 11, 8, 2));       // srl  $11 = 0084210f
        emit(rType(0, 8, 12, 8, 3));       // sra  $12 = ff84210f
        emit(rType(9, 8, 13, 0, 4));       // sllv $13 = 10f0f000
        emit(rType(9, 8, 14, 0, 6));       // srlv $14 = 00084210
        emit(rType(9, 8, 15, 0, 7));       // srav $15 = fff84210
        emit(rType(10, 11, 2, 0, 38));     // xor chain over the shifts
        emit(rType(2, 13, 2, 0, 38));
        emit(rType(2, 14, 2, 0, 38));
        emit(rType(2, 15, 2, 0, 38));
        emit(iType(43, 0, 12, 'h308));     // sw $12
        emit(rType(0, 0, 0, 0, 8));
        startTest("word and lanes 0, 2", 32'hEEDDCC44, 32'h200, 32'h11AA3380);
        emit(iType(15, 0, 8, 'h1122));
        emit(iType(13, 8, 8, 'h3344));     // $8 = 11223344
        emit(iType(43, 0, 8, 'h200));      // sw
        emit(iType(35, 0, 9, 'h200));      // lw $9 round trip
        emit(iType(9, 0, 10, 'h80));
        emit(iType(40, 0, 10, 'h200));     // sb lane 0
        emit(iType(9, 0, 11, 'hAA));
        emit(iType(40, 0, 11, 'h202));     // sb lane 2
        emit(iType(32, 0, 12, 'h200));     // lb  $12 = ffffff80
        emit(iType(36, 0, 13, 'h200));     // lbu $13 = 00000080
        emit(rType(12, 13, 2, 0, 38));     // v0 = ffffff00
        emit(rType(2, 9, 2, 0, 38));       // v0 = eeddcc44
        emit(rType(0, 0, 0, 0, 8));
        startTest("lanes 1, 3", 32'hFFFFFF5A, 32'h210, 32'hC3FF5AFF);
        emit(iType(9, 0, 8, -1));
        emit(iType(43, 0, 8, 'h210));      // sw ffffffff
        emit(iType(9, 0, 9, 'h5A));
        emit(iType(40, 0, 9, 'h211));      // sb lane 1
        emit(iType(9, 0, 10, 'hC3));
        emit(iType(40, 0, 10, 'h213));     // sb lane 3
        emit(iType(36, 0, 2, 'h213));      // lbu v0 = c3
        emit(iType(32, 0, 11, 'h213));     // lb $11 = ffffffc3
        emit(iType(36, 0, 12, 'h211));     // lbu $12 = 5a
        emit(rType(2, 11, 2, 0, 38));
        emit(rType(2, 12, 2, 0, 37));
        emit(rType(0, 0, 0, 0, 8));
        startTest("branches and jumps", 32'h56, 32'h30C, 32'h56);
        emit(iType(9, 0, 8, 1));           // 0
        emit(iType(9, 0, 9, 1));           // 1
        emit(iType(4, 8, 9, 1));           // 2  beq taken to 4
        emit(iType(13, 2, 2, 'h01));       // 3  skipped, no delay slot
        emit(iType(13, 2, 2, 'h02));       // 4
        emit(iType(5, 8, 9, 1));           // 5  bne not taken
        emit(iType(13, 2, 2, 'h04));       // 6
        emit(iType(5, 8, 0, 1));           // 7  bne taken to 9
        emit(iType(13, 2, 2, 'h08));       // 8  skipped
        emit(iType(4, 8, 0, 1));           // 9  beq not taken
        emit(iType(13, 2, 2, 'h10));       // 10
        emit(jType(13));                   // 11 j 13
        emit(iType(13, 2, 2, 'h20));       // 12 skipped
        emit(iType(13, 2, 2, 'h40));       // 13
        emit(iType(15, 0, 10, codeAddr(18) >> 16));
        emit(iType(13, 10, 10, codeAddr(18)));
        emit(rType(10, 0, 0, 0, 8));       // 16 jr $10 to 18
        emit(iType(13, 2, 2, 'h80));       // 17 skipped
        emit(iType(43, 0, 2, 'h30C));      // 18 sw $2
        emit(rType(0, 0, 0, 0, 8));
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, actual, expected);
            errorCount++;
        end
    endtask

    task automatic runTest(input int t);
        int errorsBefore;
        int busyCycles;
        errorsBefore = errorCount;
        busyCycles = 0;
        for (int i = 0; i < progLen[t]; i++) begin
            @(posedge clk);
            loadEn <= 1'b1;
            loadAddr <= codeAddr(i);
            loadData <= progWords[t][i];
        end
        @(posedge clk);
        loadEn <= 1'b0;
        reset <= 1'b1;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        do @(negedge clk); while (active);  // Watchdog bounds this
        checkValue(registerV0, expV0[t], "registerV0");
        repeat (idleCycles) begin
            @(negedge clk);
            if (read || write || active)
                busyCycles++;
        end
        checkValue(busyCycles, 0, "bus cycles after halt");
        @(posedge clk);
        peekAddr <= dataAddr[t];
        @(negedge clk);
        checkValue(peekData, expData[t], $sformatf("memory word at %h", dataAddr[t]));
        if (errorCount == errorsBefore) begin
            $display("Test %0d, %s: passed", t + 1, testName[t]);
        end else begin
            failedTests++;
            $display("Test %0d, %s: failed", t + 1, testName[t]);
        end
    endtask

    // Watchdog on a cycle budget worked out from the program lengths
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Run timed out after %0d cycles, the core did not halt", cycleCount);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int budget;
        void'($urandom(32'h9bd43221));
        reset = 1'b1;  // Held through the first load
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        peekAddr = '0;
        buildTable();
        budget = 0;
        for (int t = 0; t < numTests; t++) begin
            // One load cycle plus the worst execution per word
            budget += progLen[t] * (worstCpi + 1) + resetCycles + idleCycles + 8;
        end
        cycleLimit = 2 * budget;  // Margin over the worst case
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 numTests, numTests - failedTests, failedTests, errorCount);
        if (errorCount == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- flist.f
mipsIsaPkg.sv
cpuCorePkg.sv
regFile.sv
alu.sv
instrDecode.sv
loadStoreUnit.sv
cpuControl.sv
mipsCpuBus.sv
tbMemory.sv
tbMipsCpu.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tbMipsCpu -f flist.f -o tbMipsCpu
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tbMipsCpu)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
